// File: hw/host_pkg.sv
// ----------------------------------------
// Shared constants for the simulation host
// Register map, widths, FIFO depth, limits
// ----------------------------------------
package host_pkg;

  // APB bus widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // Counter width for instret and cycle
  localparam int CNT_W = 32;

  // Trace and profile enable bits
  localparam int N_ENABLES = 11;

  // Register offsets
  localparam logic [ADDR_W-1:0] ENABLE_OFS  = 12'h000;
  localparam logic [ADDR_W-1:0] CONTROL_OFS = 12'h004;
  localparam logic [ADDR_W-1:0] FINISH_OFS  = 12'h008;
  localparam logic [ADDR_W-1:0] PUTCHAR_OFS = 12'h00C;
  localparam logic [ADDR_W-1:0] INSTRET_OFS = 12'h010;
  localparam logic [ADDR_W-1:0] CYCLE_OFS   = 12'h014;
  localparam logic [ADDR_W-1:0] STATUS_OFS  = 12'h018;

  // Console character path
  localparam int CHAR_W     = 8;
  localparam int FIFO_DEPTH = 8;

  // Commits skipped after reset or clear
  localparam int WARMUP_INSTR = 4;

  // Idle cycles before the watchdog trips
  localparam int WATCHDOG_LIMIT = 64;

endpackage

// File: hw/host_stat_if.sv
// ----------------------------------------
// Status bundle between registers and the
// performance and watchdog monitors
// ----------------------------------------
`timescale 1ns/1ps

interface host_stat_if;
  import host_pkg::*;

  logic             freeze;
  logic             clear;
  logic [CNT_W-1:0] instret_count;
  logic [CNT_W-1:0] cycle_count;
  logic             timeout;

  modport regs (output freeze, output clear,
                input instret_count, input cycle_count, input timeout);

  modport perf (input freeze, input clear,
                output instret_count, output cycle_count);

  modport wdog (input freeze, input clear, output timeout);

endinterface

// File: hw/host_apb_regs.sv
// ----------------------------------------
// APB slave register block
// Enable, control, finish, putchar, status
// ----------------------------------------
`timescale 1ns/1ps

module host_apb_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [host_pkg::ADDR_W-1:0]   paddr_i,
  input  logic [host_pkg::DATA_W-1:0]   pwdata_i,
  output logic [host_pkg::DATA_W-1:0]   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic [host_pkg::N_ENABLES-1:0] enables_o,
  output logic                          finish_o,
  output logic                          fail_o,
  output logic                          fifo_push_o,
  output logic [host_pkg::CHAR_W-1:0]   fifo_data_o,
  input  logic                          fifo_full_i,
  host_stat_if.regs                     stat
);
  import host_pkg::*;

  logic                 access;
  logic                 unmapped;
  logic                 read_only;
  logic                 put_stall;
  logic                 wr_en;
  logic [N_ENABLES-1:0] enables_q;
  logic                 freeze_q;
  logic                 clear_q;
  logic                 finish_q;
  logic                 fail_q;

  always_comb
  begin
    unmapped  = 1'b0;
    read_only = 1'b0;
    case (paddr_i)
      ENABLE_OFS, CONTROL_OFS, FINISH_OFS, PUTCHAR_OFS: read_only = 1'b0;
      INSTRET_OFS, CYCLE_OFS, STATUS_OFS:               read_only = 1'b1;
      default:                                          unmapped  = 1'b1;
    endcase
  end

  assign access    = psel_i & penable_i;
  // Hold the access while the console FIFO has no room
  assign put_stall = pwrite_i & (paddr_i == PUTCHAR_OFS) & fifo_full_i;
  assign pready_o  = access & ~put_stall;
  assign pslverr_o = pready_o & (unmapped | (pwrite_i & read_only));
  assign wr_en     = pready_o & pwrite_i & ~pslverr_o;

  always_comb
  begin
    prdata_o = '0;
    if (access && !pwrite_i)
    begin
      case (paddr_i)
        ENABLE_OFS:  prdata_o = DATA_W'(enables_q);
        CONTROL_OFS: prdata_o = DATA_W'(freeze_q);
        FINISH_OFS:  prdata_o = DATA_W'({fail_q, finish_q});
        INSTRET_OFS: prdata_o = DATA_W'(stat.instret_count);
        CYCLE_OFS:   prdata_o = DATA_W'(stat.cycle_count);
        STATUS_OFS:  prdata_o = DATA_W'({fifo_full_i, stat.timeout});
        default:     prdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      enables_q <= '0;
      freeze_q  <= 1'b1;
      clear_q   <= 1'b0;
      finish_q  <= 1'b0;
      fail_q    <= 1'b0;
    end
    else
    begin
      clear_q <= wr_en & (paddr_i == CONTROL_OFS) & pwdata_i[1];
      if (wr_en && paddr_i == ENABLE_OFS)
        enables_q <= pwdata_i[N_ENABLES-1:0];
      if (wr_en && paddr_i == CONTROL_OFS)
        freeze_q <= pwdata_i[0];
      // First finish wins, code latched with it
      if (wr_en && paddr_i == FINISH_OFS && pwdata_i[0] && !finish_q)
      begin
        finish_q <= 1'b1;
        fail_q   <= pwdata_i[1];
      end
    end
  end

  assign fifo_push_o = wr_en & (paddr_i == PUTCHAR_OFS);
  assign fifo_data_o = pwdata_i[CHAR_W-1:0];

  assign enables_o   = enables_q;
  assign finish_o    = finish_q;
  assign fail_o      = fail_q;
  assign stat.freeze = freeze_q;
  assign stat.clear  = clear_q;

endmodule

// File: hw/char_fifo.sv
// ----------------------------------------
// Console character FIFO, ready/valid out
// ----------------------------------------
`timescale 1ns/1ps

module char_fifo (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        push_i,
  input  logic [host_pkg::CHAR_W-1:0] data_i,
  output logic                        full_o,
  output logic                        valid_o,
  output logic [host_pkg::CHAR_W-1:0] data_o,
  input  logic                        ready_i
);
  import host_pkg::*;

  logic [CHAR_W-1:0]                  mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]      wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]      rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0]    count;
  logic                               do_push;
  logic                               do_pop;

  assign valid_o = (count != '0);
  assign full_o  = (count == ($clog2(FIFO_DEPTH+1))'(FIFO_DEPTH));
  assign data_o  = mem[rd_ptr];
  assign do_push = push_i & ~full_o;
  assign do_pop  = valid_o & ready_i;

  // Storage only, pointers track occupancy
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: hw/perf_counter.sv
// ----------------------------------------
// Cycle and retired-instruction counters
// with a warm-up skip after clear
// ----------------------------------------
`timescale 1ns/1ps

module perf_counter (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      commit_i,
  host_stat_if.perf stat
);
  import host_pkg::*;

  logic [CNT_W-1:0]                  cycle_q;
  logic [CNT_W-1:0]                  instret_q;
  logic [$clog2(WARMUP_INSTR+1)-1:0] warm_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cycle_q   <= '0;
      instret_q <= '0;
      warm_q    <= '0;
    end
    else if (stat.clear)
    begin
      cycle_q   <= '0;
      instret_q <= '0;
      warm_q    <= '0;
    end
    else if (!stat.freeze)
    begin
      cycle_q <= cycle_q + 1'b1;
      if (commit_i)
      begin
        // Early commits only advance the warm-up count
        if (warm_q < WARMUP_INSTR)
          warm_q <= warm_q + 1'b1;
        else
          instret_q <= instret_q + 1'b1;
      end
    end
  end

  assign stat.cycle_count   = cycle_q;
  assign stat.instret_count = instret_q;

endmodule

// File: hw/commit_watchdog.sv
// ----------------------------------------
// Commit watchdog with sticky timeout
// ----------------------------------------
`timescale 1ns/1ps

module commit_watchdog (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      commit_i,
  host_stat_if.wdog stat
);
  import host_pkg::*;

  logic [$clog2(WATCHDOG_LIMIT+1)-1:0] idle_q;
  logic                                timeout_q;
  logic                                limit_hit;

  // Next idle cycle lands on the limit
  assign limit_hit = !commit_i && (idle_q == WATCHDOG_LIMIT - 1);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      idle_q    <= '0;
      timeout_q <= 1'b0;
    end
    else if (stat.clear)
    begin
      idle_q    <= '0;
      timeout_q <= 1'b0;
    end
    else if (!stat.freeze)
    begin
      if (commit_i)
        idle_q <= '0;
      else if (idle_q != WATCHDOG_LIMIT)
        idle_q <= idle_q + 1'b1;
      // Sticky until clear
      if (limit_hit)
        timeout_q <= 1'b1;
    end
  end

  assign stat.timeout = timeout_q;

endmodule

// File: hw/sim_host_top.sv
// ----------------------------------------
// Simulation host top level
// ----------------------------------------
`timescale 1ns/1ps

module sim_host_top (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [host_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [host_pkg::DATA_W-1:0]    pwdata_i,
  input  logic                           commit_i,
  input  logic                           char_ready_i,
  output logic [host_pkg::DATA_W-1:0]    prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,
  output logic [host_pkg::N_ENABLES-1:0] enables_o,
  output logic                           finish_o,
  output logic                           fail_o,
  output logic                           char_valid_o,
  output logic [host_pkg::CHAR_W-1:0]    char_o
);

  logic                        fifo_push;
  logic [host_pkg::CHAR_W-1:0] fifo_data;
  logic                        fifo_full;

  host_stat_if u_stat ();

  host_apb_regs u_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .enables_o   (enables_o),
    .finish_o    (finish_o),
    .fail_o      (fail_o),
    .fifo_push_o (fifo_push),
    .fifo_data_o (fifo_data),
    .fifo_full_i (fifo_full),
    .stat        (u_stat)
  );

  char_fifo u_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (fifo_push),
    .data_i   (fifo_data),
    .full_o   (fifo_full),
    .valid_o  (char_valid_o),
    .data_o   (char_o),
    .ready_i  (char_ready_i)
  );

  perf_counter u_perf (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .commit_i (commit_i),
    .stat     (u_stat)
  );

  commit_watchdog u_wdog (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .commit_i (commit_i),
    .stat     (u_stat)
  );

endmodule

// File: verification/sim_host_props.sv
// ----------------------------------------
// Bound assertions on APB and console
// ----------------------------------------
`timescale 1ns/1ps

module sim_host_props (
  input logic                        clk_i,
  input logic                        arst_n_i,
  input logic                        psel_i,
  input logic                        pwrite_i,
  input logic [host_pkg::ADDR_W-1:0] paddr_i,
  input logic                        pready_o,
  input logic                        pslverr_o,
  input logic                        char_valid_o,
  input logic                        char_ready_i,
  input logic [host_pkg::CHAR_W-1:0] char_o
);

  err_with_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pslverr_o |-> pready_o)
    else $error("pslverr raised without pready");

  // Master holds the request until the slave is ready
  apb_request_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (psel_i && !pready_o) |=> ($stable(paddr_i) && $stable(pwrite_i)))
    else $error("paddr or pwrite changed during a pending APB access");

  char_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (char_valid_o && !char_ready_i) |=> $stable(char_o))
    else $error("char_o changed while waiting for char_ready_i");

endmodule

bind sim_host_top sim_host_props u_props (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .psel_i       (psel_i),
  .pwrite_i     (pwrite_i),
  .paddr_i      (paddr_i),
  .pready_o     (pready_o),
  .pslverr_o    (pslverr_o),
  .char_valid_o (char_valid_o),
  .char_ready_i (char_ready_i),
  .char_o       (char_o)
);

// File: verification/tb_sim_host.sv
// ----------------------------------------
// Testbench for the simulation host
// Case-file driven APB, commit and console
// ----------------------------------------
`timescale 1ns/1ps

module tb_sim_host;
  import host_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int CYCLES_PER_CASE = 200;
  localparam int STALL_LIMIT     = 150;
  localparam int DRAIN_LIMIT     = 200;
  localparam int MAX_CASES       = 64;

  logic                 clk;
  logic                 arst_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [ADDR_W-1:0]    paddr;
  logic [DATA_W-1:0]    pwdata;
  logic                 commit;
  logic                 char_ready;
  logic [DATA_W-1:0]    prdata;
  logic                 pready;
  logic                 pslverr;
  logic [N_ENABLES-1:0] enables;
  logic                 finish;
  logic                 fail;
  logic                 char_valid;
  logic [CHAR_W-1:0]    char_out;

  logic [31:0]       cases_mem [0:4*MAX_CASES-1];
  logic [CHAR_W-1:0] exp_chars [$];
  logic [CHAR_W-1:0] exp_char;
  int                n_cases;
  int                errors;
  int                checks;
  int                ready_mode;
  int                sink_mode;

  sim_host_top uut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .commit_i     (commit),
    .char_ready_i (char_ready),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .enables_o    (enables),
    .finish_o     (finish),
    .fail_o       (fail),
    .char_valid_o (char_valid),
    .char_o       (char_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Mode 0 stalls at random, mode 1 holds ready low and others keep it high
  always @(posedge clk)
  begin
    sink_mode = ready_mode;
    #2;
    case (sink_mode)
      0:       char_ready = $urandom % 2;
      1:       char_ready = 1'b0;
      default: char_ready = 1'b1;
    endcase
  end

  // A character leaves on the next rising edge
  always @(negedge clk)
  begin
    if (arst_n && char_valid && char_ready)
    begin
      if (exp_chars.size() == 0)
      begin
        $display("Console sent character %h at %0t when none was expected", char_out, $time);
        errors++;
      end
      else
      begin
        exp_char = exp_chars.pop_front();
        check_value(char_out, exp_char, "console character");
      end
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    int waits;
    waits   = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready && waits < STALL_LIMIT)
    begin
      @(negedge clk);
      waits++;
    end
    if (!pready)
    begin
      $display("APB access to %h never completed, pready stayed low", addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic drain_console(input int line);
    int waits;
    waits = 0;
    while (exp_chars.size() != 0 && waits < DRAIN_LIMIT)
    begin
      wait_cycles(1);
      waits++;
    end
    if (exp_chars.size() != 0)
    begin
      $display("Case %0d: %0d console characters never arrived", line, exp_chars.size());
      errors++;
      exp_chars.delete();
    end
  endtask

  // Columns are operation, address, data and expected value
  task automatic run_case(input int line);
    logic [31:0]       op;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    logic [31:0]       exp;
    logic [31:0]       rdata;
    logic              err;
    op   = cases_mem[4*line];
    addr = cases_mem[4*line+1][ADDR_W-1:0];
    data = cases_mem[4*line+2];
    exp  = cases_mem[4*line+3];
    if (op == 0 || op == 1 || op == 6)
      wait_cycles($urandom % 4);
    case (op)
      0:
      begin
        apb_transfer(1'b1, addr, data, rdata, err);
        if (err !== exp[0])
        begin
          $display("Case %0d: write to %h gave pslverr %b where %b was expected",
                   line, addr, err, exp[0]);
          errors++;
        end
        if (addr == PUTCHAR_OFS && !err)
          exp_chars.push_back(data[CHAR_W-1:0]);
      end
      1, 6:
      begin
        apb_transfer(1'b0, addr, '0, rdata, err);
        if (err !== data[0])
        begin
          $display("Case %0d: read of %h gave pslverr %b where %b was expected",
                   line, addr, err, data[0]);
          errors++;
        end
        if (op == 1)
          check_value(rdata, exp, $sformatf("case %0d read of %h", line, addr));
        else
          check_value(rdata >= exp, 1, $sformatf("case %0d lower bound of %h", line, addr));
      end
      2:
      begin
        commit = 1'b1;
        wait_cycles(data);
        commit = 1'b0;
      end
      3: wait_cycles(data);
      4: drain_console(line);
      5: ready_mode = data;
      7:
      begin
        if (addr == 0)
          check_value(enables, exp, $sformatf("case %0d enables", line));
        else
          check_value({fail, finish}, exp, $sformatf("case %0d fail and finish", line));
      end
      default:
      begin
        $display("Case %0d has unknown operation %h", line, op);
        errors++;
      end
    endcase
  endtask

  initial
  begin
    @(posedge arst_n);
    wait (n_cases > 0);
    #((n_cases * CYCLES_PER_CASE + RESET_CYCLES) * CLK_PERIOD);
    $display("Run stopped after %0d cycles without finishing", n_cases * CYCLES_PER_CASE);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    int seed;
    seed       = $urandom(63);
    clk        = 1'b0;
    arst_n     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    commit     = 1'b0;
    char_ready = 1'b0;
    ready_mode = 2;
    errors     = 0;
    checks     = 0;
    $readmemh("verification/sim_host_cases.txt", cases_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && ^cases_mem[4*n_cases] !== 1'bx)
      n_cases++;
    if (n_cases == 0)
    begin
      $display("No cases could be read from the case file");
      errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_value({enables, finish, fail, char_valid, pready}, '0, "outputs after reset");
    for (int i = 0; i < n_cases; i++)
      run_case(i);
    wait_cycles(4);
    $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: verification/sim_host_cases.txt
// op addr data expect, op 0 write (expect pslverr), 1 read (data pslverr), 2 commits,
// 3 idle, 4 console drain, 5 ready mode, 6 read at least expect, 7 pins (0 en, 1 fin)
0 000 FFFFFFFF 0
1 000 0 7FF
7 000 0 7FF
0 000 525 0
0 010 1234 1
1 010 0 0
0 020 FFFF 1
1 020 1 0
7 000 0 525
7 001 0 0
0 008 3 0
7 001 0 3
0 008 0 0
0 008 1 0
1 008 0 3
5 000 0 0
0 00C 48 0
0 00C 69 0
0 00C 21 0
4 000 0 0
5 000 1 0
0 00C 30 0
0 00C 31 0
0 00C 32 0
0 00C 33 0
0 00C 34 0
0 00C 35 0
0 00C 36 0
0 00C 37 0
1 018 0 2
5 000 0 0
4 000 0 0
1 018 0 0
0 004 2 0
3 000 2 0
2 000 A 0
1 010 0 6
6 014 0 6
3 000 4A 0
1 018 0 1
0 004 2 0
1 018 0 0
3 000 2 0
2 000 7 0
0 004 1 0
1 010 0 3
2 000 5 0
1 010 0 3
3 000 50 0
1 018 0 0

// File: list.f
hw/host_pkg.sv
hw/host_stat_if.sv
hw/host_apb_regs.sv
hw/char_fifo.sv
hw/perf_counter.sv
hw/commit_watchdog.sv
hw/sim_host_top.sv
verification/sim_host_props.sv
verification/tb_sim_host.sv

// File: Bender.yml
package:
  name: sim_host

sources:
  - hw/host_pkg.sv
  - hw/host_stat_if.sv
  - hw/host_apb_regs.sv
  - hw/char_fifo.sv
  - hw/perf_counter.sv
  - hw/commit_watchdog.sv
  - hw/sim_host_top.sv
  - target: simulation
    files:
      - verification/sim_host_props.sv
      - verification/tb_sim_host.sv
